/* design/dmni_pkg.sv */
package dmni_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int FLIT_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int SIZE_W      = 32;
    localparam int WORD_BYTES  = 4;
    // Quantum of 15 cycles per grant
    localparam int ARB_TIMER_W = 4;

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [SIZE_W-1:0] size_t;
    typedef logic [3:0]        mem_be_t;

    ////////////////////////////////////////////////////////////////////////////
    // Operations and states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        DMA_OP_SEND    = 1'b0,
        DMA_OP_RECEIVE = 1'b1
    } dma_op_e;

    typedef enum logic {
        ARB_SRC_SEND    = 1'b0,
        ARB_SRC_RECEIVE = 1'b1
    } arb_src_e;

    typedef enum logic [2:0] {
        RECV_HEADER = 3'b001,
        RECV_WAIT   = 3'b010,
        RECV_DATA   = 3'b100
    } recv_state_e;

    typedef enum logic [3:0] {
        SEND_IDLE    = 4'b0001,
        SEND_PRELOAD = 4'b0010,
        SEND_DATA    = 4'b0100,
        SEND_STOP    = 4'b1000
    } send_state_e;

endpackage

/* design/dmni_receive.sv */
module dmni_receive import dmni_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    noc_rx_i,
    input  logic    noc_eop_i,
    input  logic    start_i,
    input  dma_op_e operation_i,
    input  addr_t   address_i,
    input  size_t   size_i,
    input  logic    grant_i,
    output logic    noc_credit_o,
    output logic    pending_o,
    output logic    discard_o,
    output addr_t   addr_o,
    output logic    active_o,
    output logic    available_o
);

    recv_state_e state_q;
    recv_state_e state_d;
    addr_t       addr_q;
    size_t       size_q;
    logic        discard_q;
    logic        load_cmd;
    logic        take;

    assign load_cmd = (state_q == RECV_WAIT) && start_i && (operation_i == DMA_OP_RECEIVE);
    // Payload flit moves into memory this cycle
    assign take = (state_q == RECV_DATA) && noc_rx_i && grant_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RECV_HEADER: begin
                if (noc_rx_i) begin
                    state_d = RECV_WAIT;
                end
            end
            RECV_WAIT: begin
                if (load_cmd) begin
                    state_d = RECV_DATA;
                end
            end
            RECV_DATA: begin
                if (take && noc_eop_i) begin
                    state_d = RECV_HEADER;
                end else if (take && size_q == size_t'(1)) begin
                    state_d = RECV_WAIT;
                end
            end
            default: state_d = RECV_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= RECV_HEADER;
            addr_q    <= '0;
            size_q    <= '0;
            discard_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (load_cmd) begin
                addr_q    <= address_i;
                size_q    <= size_i;
                // Zero address drops the whole programmed chunk
                discard_q <= (address_i == '0);
            end else if (take) begin
                addr_q <= addr_q + addr_t'(WORD_BYTES);
                size_q <= size_q - size_t'(1);
            end
        end
    end

    // Header needs no memory, so credit is free there
    always_comb begin
        case (state_q)
            RECV_DATA: noc_credit_o = grant_i;
            RECV_WAIT: noc_credit_o = 1'b0;
            default:   noc_credit_o = 1'b1;
        endcase
    end

    assign pending_o   = (state_q == RECV_DATA) && noc_rx_i;
    assign discard_o   = discard_q;
    assign addr_o      = addr_q;
    assign active_o    = (state_q == RECV_DATA);
    assign available_o = (state_q == RECV_WAIT);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q == RECV_WAIT |-> !noc_credit_o)
        else $error("receive credit raised while waiting for a command");

endmodule

/* design/dmni_send.sv */
module dmni_send import dmni_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    noc_ack_i,
    input  logic    start_i,
    input  dma_op_e operation_i,
    input  addr_t   address_i,
    input  addr_t   address_2_i,
    input  size_t   size_i,
    input  size_t   size_2_i,
    input  logic    grant_i,
    output logic    noc_tx_o,
    output logic    noc_eop_o,
    output logic    pending_o,
    output addr_t   addr_o,
    output logic    active_o
);

    send_state_e state_q;
    send_state_e state_d;
    addr_t       addr_q;
    addr_t       addr_2_q;
    size_t       size_q;
    size_t       size_2_q;
    addr_t       addr_sh_q;
    addr_t       addr_2_sh_q;
    size_t       size_sh_q;
    size_t       size_2_sh_q;
    logic        can_send;
    logic        can_send_q;
    logic        last_read;

    assign can_send  = noc_ack_i && grant_i;
    // Exactly one word left to read over both segments
    assign last_read = (size_q == size_t'(1) && size_2_q == '0)
                    || (size_q == '0 && size_2_q == size_t'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEND_IDLE: begin
                if (start_i && operation_i == DMA_OP_SEND) begin
                    state_d = SEND_PRELOAD;
                end
            end
            SEND_PRELOAD: begin
                if (can_send) begin
                    state_d = last_read ? SEND_STOP : SEND_DATA;
                end
            end
            SEND_DATA: begin
                if (!can_send) begin
                    state_d = SEND_PRELOAD;
                end else if (last_read) begin
                    state_d = SEND_STOP;
                end
            end
            SEND_STOP: state_d = can_send ? SEND_IDLE : SEND_PRELOAD;
            default:   state_d = SEND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= SEND_IDLE;
            can_send_q <= 1'b0;
            addr_q     <= '0;
            addr_2_q   <= '0;
            size_q     <= '0;
            size_2_q   <= '0;
        end else begin
            state_q    <= state_d;
            can_send_q <= can_send;
            if (state_q == SEND_IDLE) begin
                addr_q   <= address_i;
                addr_2_q <= address_2_i;
                size_q   <= size_i;
                size_2_q <= size_2_i;
            end else if (can_send && state_q inside {SEND_PRELOAD, SEND_DATA}) begin
                if (size_q != '0) begin
                    addr_q <= addr_q + addr_t'(WORD_BYTES);
                    size_q <= size_q - size_t'(1);
                end else begin
                    addr_2_q <= addr_2_q + addr_t'(WORD_BYTES);
                    size_2_q <= size_2_q - size_t'(1);
                end
            end else if (!can_send && can_send_q) begin
                // Read data lags by one cycle, so step back to the unsent word
                addr_q   <= addr_sh_q;
                addr_2_q <= addr_2_sh_q;
                size_q   <= size_sh_q;
                size_2_q <= size_2_sh_q;
            end
        end
    end

    // Counters as they stood at the last accepted cycle
    always_ff @(posedge clk_i) begin
        if (state_q == SEND_IDLE) begin
            addr_sh_q   <= address_i;
            addr_2_sh_q <= address_2_i;
            size_sh_q   <= size_i;
            size_2_sh_q <= size_2_i;
        end else if (can_send) begin
            addr_sh_q   <= addr_q;
            addr_2_sh_q <= addr_2_q;
            size_sh_q   <= size_q;
            size_2_sh_q <= size_2_q;
        end
    end

    assign noc_tx_o  = (state_q inside {SEND_DATA, SEND_STOP}) && grant_i;
    assign noc_eop_o = (state_q == SEND_STOP) && grant_i;
    assign pending_o = (state_q != SEND_IDLE);
    assign addr_o    = (size_q != '0) ? addr_q : addr_2_q;
    assign active_o  = (state_q != SEND_IDLE);

    // Last flit only after a nonzero count drained with the final read accepted
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_eop_o |-> state_q == SEND_STOP && size_q == '0 && size_2_q == '0
                      && $past(can_send))
        else $error("send eop raised outside a completed transfer");

endmodule

/* design/dmni_mem_arbiter.sv */
module dmni_mem_arbiter import dmni_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    send_pend_i,
    input  logic    recv_pend_i,
    input  logic    recv_discard_i,
    input  addr_t   send_addr_i,
    input  addr_t   recv_addr_i,
    input  flit_t   noc_data_i,
    output logic    send_grant_o,
    output logic    recv_grant_o,
    output logic    mem_en_o,
    output mem_be_t mem_we_o,
    output addr_t   mem_addr_o,
    output flit_t   mem_data_o
);

    arb_src_e               cur_q;
    arb_src_e               other;
    logic [ARB_TIMER_W-1:0] timer_q;
    logic                   cur_pend;
    logic                   other_pend;
    logic                   switch_src;

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin with quantum
    ////////////////////////////////////////////////////////////////////////////

    assign other      = (cur_q == ARB_SRC_SEND) ? ARB_SRC_RECEIVE : ARB_SRC_SEND;
    assign cur_pend   = (cur_q == ARB_SRC_SEND) ? send_pend_i : recv_pend_i;
    assign other_pend = (cur_q == ARB_SRC_SEND) ? recv_pend_i : send_pend_i;
    assign switch_src = other_pend && (timer_q == '0 || !cur_pend);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cur_q   <= ARB_SRC_SEND;
            timer_q <= '0;
        end else if (switch_src) begin
            cur_q   <= other;
            timer_q <= '1;
        end else if (timer_q != '0) begin
            timer_q <= timer_q - 1'b1;
        end
    end

    assign send_grant_o = (cur_q == ARB_SRC_SEND);
    assign recv_grant_o = (cur_q == ARB_SRC_RECEIVE);

    ////////////////////////////////////////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (cur_q == ARB_SRC_SEND) begin
            mem_en_o   = send_pend_i;
            mem_we_o   = '0;
            mem_addr_o = send_addr_i;
        end else begin
            mem_en_o   = recv_pend_i && !recv_discard_i;
            mem_we_o   = '1;
            mem_addr_o = recv_addr_i;
        end
    end

    // Only the receive engine ever writes
    assign mem_data_o = noc_data_i;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_en_o |-> (send_grant_o ? send_pend_i : recv_pend_i))
        else $error("memory enabled for a client with nothing pending");

endmodule

/* design/dmni_dma.sv */
module dmni_dma import dmni_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,

    // Hermes receive port
    input  logic    noc_rx_i,
    input  logic    noc_eop_i,
    output logic    noc_credit_o,
    input  flit_t   noc_data_i,

    // Hermes send port
    output logic    noc_tx_o,
    output logic    noc_eop_o,
    input  logic    noc_ack_i,
    output flit_t   noc_data_o,

    // Local memory
    output logic    mem_en_o,
    output mem_be_t mem_we_o,
    output addr_t   mem_addr_o,
    input  flit_t   mem_data_i,
    output flit_t   mem_data_o,

    // Host configuration and status
    input  logic    start_i,
    input  dma_op_e operation_i,
    input  size_t   size_i,
    input  size_t   size_2_i,
    input  addr_t   address_i,
    input  addr_t   address_2_i,
    output logic    send_active_o,
    output logic    receive_active_o,
    output logic    receive_available_o
);

    logic  send_pend;
    logic  recv_pend;
    logic  recv_discard;
    logic  send_grant;
    logic  recv_grant;
    addr_t send_addr;
    addr_t recv_addr;

    dmni_receive u_receive (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .noc_rx_i     (noc_rx_i),
        .noc_eop_i    (noc_eop_i),
        .start_i      (start_i),
        .operation_i  (operation_i),
        .address_i    (address_i),
        .size_i       (size_i),
        .grant_i      (recv_grant),
        .noc_credit_o (noc_credit_o),
        .pending_o    (recv_pend),
        .discard_o    (recv_discard),
        .addr_o       (recv_addr),
        .active_o     (receive_active_o),
        .available_o  (receive_available_o)
    );

    dmni_send u_send (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .noc_ack_i   (noc_ack_i),
        .start_i     (start_i),
        .operation_i (operation_i),
        .address_i   (address_i),
        .address_2_i (address_2_i),
        .size_i      (size_i),
        .size_2_i    (size_2_i),
        .grant_i     (send_grant),
        .noc_tx_o    (noc_tx_o),
        .noc_eop_o   (noc_eop_o),
        .pending_o   (send_pend),
        .addr_o      (send_addr),
        .active_o    (send_active_o)
    );

    dmni_mem_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .send_pend_i    (send_pend),
        .recv_pend_i    (recv_pend),
        .recv_discard_i (recv_discard),
        .send_addr_i    (send_addr),
        .recv_addr_i    (recv_addr),
        .noc_data_i     (noc_data_i),
        .send_grant_o   (send_grant),
        .recv_grant_o   (recv_grant),
        .mem_en_o       (mem_en_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_data_o     (mem_data_o)
    );

    // Read word goes out on the NoC in the cycle it returns
    assign noc_data_o = mem_data_i;

endmodule

/* dv/tb_mem_model.sv */
module tb_mem_model import dmni_pkg::*; #(
    parameter int WORDS = 1024
) (
    input  logic    clk_i,
    input  logic    en_i,
    input  mem_be_t we_i,
    input  addr_t   addr_i,
    input  flit_t   wdata_i,
    output flit_t   rdata_o
);

    timeunit 1ns;
    timeprecision 1ps;

    flit_t       mem [WORDS];
    flit_t       merged;
    logic [31:0] idx;

    assign idx = (addr_i / WORD_BYTES) % WORDS;

    // Each word starts out tagged with its own byte address
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 32'hC0DE_0000 ^ flit_t'(i * WORD_BYTES);
        end
        rdata_o = '0;
    end

    always @(posedge clk_i) begin
        if (en_i && we_i == '0) begin
            rdata_o <= mem[idx];
        end else if (en_i) begin
            merged = mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (we_i[b]) begin
                    merged[8*b +: 8] = wdata_i[8*b +: 8];
                end
            end
            mem[idx] <= merged;
        end
    end

endmodule

/* dv/tb_dmni_dma.sv */
module tb_dmni_dma import dmni_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 4;
    localparam int          TIMEOUT    = 2000;
    localparam int          MEM_WORDS  = 1024;
    localparam logic [31:0] SEED       = 32'd50;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam int          ST_AVAIL   = 0;
    localparam int          ST_RECV    = 1;
    localparam int          ST_SEND    = 2;

    logic    clk_i = 1'b0;
    logic    rst_ni;
    logic    noc_rx_i;
    logic    noc_eop_i;
    logic    noc_credit_o;
    flit_t   noc_data_i;
    logic    noc_tx_o;
    logic    noc_eop_o;
    logic    noc_ack_i;
    flit_t   noc_data_o;
    logic    mem_en_o;
    mem_be_t mem_we_o;
    addr_t   mem_addr_o;
    flit_t   mem_data_i;
    flit_t   mem_data_o;
    logic    start_i;
    dma_op_e operation_i;
    size_t   size_i;
    size_t   size_2_i;
    addr_t   address_i;
    addr_t   address_2_i;
    logic    send_active_o;
    logic    receive_active_o;
    logic    receive_available_o;

    flit_t       rx_flits [64];
    flit_t       tx_words [64];
    flit_t       tx_seen [64];
    logic        tx_eop [64];
    int          tx_count;
    logic [31:0] lfsr_q;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    dmni_dma dut0 (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .noc_rx_i            (noc_rx_i),
        .noc_eop_i           (noc_eop_i),
        .noc_credit_o        (noc_credit_o),
        .noc_data_i          (noc_data_i),
        .noc_tx_o            (noc_tx_o),
        .noc_eop_o           (noc_eop_o),
        .noc_ack_i           (noc_ack_i),
        .noc_data_o          (noc_data_o),
        .mem_en_o            (mem_en_o),
        .mem_we_o            (mem_we_o),
        .mem_addr_o          (mem_addr_o),
        .mem_data_i          (mem_data_i),
        .mem_data_o          (mem_data_o),
        .start_i             (start_i),
        .operation_i         (operation_i),
        .size_i              (size_i),
        .size_2_i            (size_2_i),
        .address_i           (address_i),
        .address_2_i         (address_2_i),
        .send_active_o       (send_active_o),
        .receive_active_o    (receive_active_o),
        .receive_available_o (receive_available_o)
    );

    tb_mem_model #(.WORDS(MEM_WORDS)) u_mem (
        .clk_i   (clk_i),
        .en_i    (mem_en_o),
        .we_i    (mem_we_o),
        .addr_i  (mem_addr_o),
        .wdata_i (mem_data_o),
        .rdata_o (mem_data_i)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = galois_step(lfsr_q);
        end
    endtask

    function automatic int word_index(input addr_t a);
        return int'((a / WORD_BYTES) % MEM_WORDS);
    endfunction

    function automatic flit_t mem_word(input addr_t a);
        return u_mem.mem[word_index(a)];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic logic status(input int sel);
        case (sel)
            ST_AVAIL: return receive_available_o;
            ST_RECV:  return receive_active_o;
            default:  return send_active_o;
        endcase
    endfunction

    // Sampled mid-cycle, returns on the following rising edge
    task automatic wait_status(input int sel, input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (status(sel) !== level && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (status(sel) !== level) begin
            errors++;
            $display("timeout at %0t ns while waiting for %s", $time, what);
        end
        @(posedge clk_i);
    endtask

    task automatic pulse_start(input dma_op_e op, input addr_t a1, input size_t n1,
                               input addr_t a2, input size_t n2);
        start_i     <= 1'b1;
        operation_i <= op;
        address_i   <= a1;
        size_i      <= n1;
        address_2_i <= a2;
        size_2_i    <= n2;
        @(posedge clk_i);
        start_i <= 1'b0;
    endtask

    task automatic program_receive(input addr_t a, input size_t n);
        wait_status(ST_AVAIL, 1'b1, "receive_available_o");
        pulse_start(DMA_OP_RECEIVE, a, n, '0, '0);
    endtask

    task automatic fill_payload(input int n);
        int          i;
        logic [31:0] w;
        for (i = 0; i < n; i++) begin
            draw_bits(32, w);
            rx_flits[i] = w;
        end
    endtask

    task automatic preload_send(input addr_t a1, input int n1, input addr_t a2, input int n2);
        int          i;
        logic [31:0] w;
        for (i = 0; i < n1 + n2; i++) begin
            draw_bits(32, w);
            tx_words[i] = w;
            if (i < n1) begin
                u_mem.mem[word_index(a1 + WORD_BYTES * i)] = w;
            end else begin
                u_mem.mem[word_index(a2 + WORD_BYTES * (i - n1))] = w;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Hermes drivers
    ////////////////////////////////////////////////////////////////////////////

    // Header first, then rx_flits, eop on the last one
    task automatic drive_packet(input int n);
        int   i;
        int   wait_cycles;
        logic taken;
        for (i = -1; i < n; i++) begin
            noc_rx_i <= 1'b1;
            if (i < 0) begin
                noc_data_i <= flit_t'(32'h0000_0100 + n);
            end else begin
                noc_data_i <= rx_flits[i];
            end
            noc_eop_i   <= (i == n - 1);
            taken       = 1'b0;
            wait_cycles = 0;
            while (!taken && wait_cycles < TIMEOUT) begin
                @(negedge clk_i);
                taken = noc_credit_o;
                @(posedge clk_i);
                wait_cycles++;
            end
            if (!taken) begin
                errors++;
                $display("flit %0d of a %0d-flit packet was never accepted", i + 1, n);
                break;
            end
        end
        noc_rx_i  <= 1'b0;
        noc_eop_i <= 1'b0;
    endtask

    task automatic collect_send();
        int          wait_cycles;
        logic [31:0] ack_bit;
        logic        busy;
        tx_count    = 0;
        wait_cycles = 0;
        do begin
            draw_bits(1, ack_bit);
            noc_ack_i <= ack_bit[0];
            @(negedge clk_i);
            if (noc_tx_o && noc_ack_i && tx_count < 64) begin
                tx_seen[tx_count] = noc_data_o;
                tx_eop[tx_count]  = noc_eop_o;
                tx_count++;
            end
            busy = send_active_o;
            @(posedge clk_i);
            wait_cycles++;
        end while (busy && wait_cycles < TIMEOUT);
        noc_ack_i <= 1'b0;
        if (busy) begin
            errors++;
            $display("send engine still active after %0d cycles", TIMEOUT);
        end
    endtask

    task automatic check_send(input int n);
        int i;
        check_value("send flit count", n, tx_count);
        for (i = 0; i < n && i < tx_count; i++) begin
            check_value($sformatf("noc_data_o[%0d]", i), tx_words[i], tx_seen[i]);
            check_value($sformatf("noc_eop_o[%0d]", i), (i == n - 1), tx_eop[i]);
        end
    endtask

    task automatic check_receive_mem(input addr_t base, input int n);
        int    i;
        addr_t a;
        for (i = 0; i < n; i++) begin
            a = base + WORD_BYTES * i;
            check_value($sformatf("mem[0x%0h]", a), rx_flits[i], mem_word(a));
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int err0;
        err0 = errors;
        @(negedge clk_i);
        check_value("noc_tx_o", 0, noc_tx_o);
        check_value("noc_eop_o", 0, noc_eop_o);
        check_value("mem_en_o", 0, mem_en_o);
        check_value("send_active_o", 0, send_active_o);
        check_value("receive_active_o", 0, receive_active_o);
        check_value("receive_available_o", 0, receive_available_o);
        check_value("noc_credit_o", 1, noc_credit_o);
        @(posedge clk_i);
        finish_test("reset_state", err0);
    endtask

    task automatic test_receive_whole();
        int    err0;
        addr_t base;
        flit_t below;
        flit_t above;
        err0  = errors;
        base  = 32'h100;
        below = mem_word(base - WORD_BYTES);
        above = mem_word(base + 8 * WORD_BYTES);
        fill_payload(8);
        fork
            drive_packet(8);
            program_receive(base, 8);
        join
        @(negedge clk_i);
        check_receive_mem(base, 8);
        check_value("mem below payload", below, mem_word(base - WORD_BYTES));
        check_value("mem above payload", above, mem_word(base + 8 * WORD_BYTES));
        check_value("receive_available_o", 0, receive_available_o);
        check_value("receive_active_o", 0, receive_active_o);
        @(posedge clk_i);
        finish_test("receive_whole", err0);
    endtask

    task automatic test_receive_split();
        int    err0;
        int    i;
        addr_t base;
        addr_t spots [4];
        flit_t saved [4];
        err0     = errors;
        base     = 32'h200;
        spots[0] = base + 4 * WORD_BYTES;
        spots[1] = base + 5 * WORD_BYTES;
        spots[2] = 32'h0;
        spots[3] = WORD_BYTES;
        for (i = 0; i < 4; i++) begin
            saved[i] = mem_word(spots[i]);
        end
        fill_payload(6);
        fork
            drive_packet(6);
            begin
                program_receive(base, 4);
                // Rest of the packet goes to address zero and is dropped
                program_receive(32'h0, 2);
            end
        join
        @(negedge clk_i);
        check_receive_mem(base, 4);
        for (i = 0; i < 4; i++) begin
            check_value($sformatf("mem[0x%0h]", spots[i]), saved[i], mem_word(spots[i]));
        end
        check_value("receive_active_o", 0, receive_active_o);
        @(posedge clk_i);
        finish_test("receive_split_discard", err0);
    endtask

    task automatic test_send_backpressure();
        int err0;
        err0 = errors;
        preload_send(32'h300, 3, 32'h380, 5);
        pulse_start(DMA_OP_SEND, 32'h300, 3, 32'h380, 5);
        collect_send();
        check_send(8);
        finish_test("send_two_segments", err0);
    endtask

    task automatic test_concurrent();
        int err0;
        err0 = errors;
        preload_send(32'h400, 12, 32'h480, 8);
        fill_payload(20);
        pulse_start(DMA_OP_SEND, 32'h400, 12, 32'h480, 8);
        fork
            collect_send();
            drive_packet(20);
            program_receive(32'h600, 20);
        join
        wait_status(ST_SEND, 1'b0, "send_active_o to fall");
        wait_status(ST_RECV, 1'b0, "receive_active_o to fall");
        check_send(20);
        check_receive_mem(32'h600, 20);
        finish_test("send_and_receive", err0);
    endtask

    initial begin
        lfsr_q      = SEED;
        rst_ni      = 1'b0;
        noc_rx_i    = 1'b0;
        noc_eop_i   = 1'b0;
        noc_data_i  = '0;
        noc_ack_i   = 1'b0;
        start_i     = 1'b0;
        operation_i = DMA_OP_SEND;
        size_i      = '0;
        size_2_i    = '0;
        address_i   = '0;
        address_2_i = '0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;

        test_reset_state();
        test_receive_whole();
        test_receive_split();
        test_send_backpressure();
        test_concurrent();

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
design/dmni_pkg.sv
design/dmni_receive.sv
design/dmni_send.sv
design/dmni_mem_arbiter.sv
design/dmni_dma.sv
dv/tb_mem_model.sv
dv/tb_dmni_dma.sv

/* Bender.yml */
package:
  name: dmni_dma

sources:
  - files:
      - design/dmni_pkg.sv
      - design/dmni_receive.sv
      - design/dmni_send.sv
      - design/dmni_mem_arbiter.sv
      - design/dmni_dma.sv
  - target: test
    files:
      - dv/tb_mem_model.sv
      - dv/tb_dmni_dma.sv
